/* all.f */
+incdir+.
axi_pkg.sv
arb_pkg.sv
rd_request_select.sv
rd_owner_fsm.sv
rd_channel_steer.sv
axi_read_arbiter.sv
tb_axi_read_arbiter.sv

/* run.sh */
#!/bin/bash
# Build and run the arbiter testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f all.f --top-module tb_axi_read_arbiter \
    -o sim_tb > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/sim_tb > sim.log 2>&1
cat sim.log
grep -q "FAIL: see errors above" sim.log && exit 1 || grep -q "PASS: all tests" sim.log || exit 1

/* tb_axi_read_arbiter.sv */
`timescale 1ns/1ns
`include "arb_defines.svh"

module tb_axi_read_arbiter;

    logic clk = 1'b0;
    logic rst = 1'b1;
    logic ar_valid [2];
    logic [31:0] ar_addr [2];
    logic [7:0] ar_len [2];
    logic mst_rready [2];
    logic sl_arready [2];
    logic sl_rvalid [2];
    logic [1:0] sl_rresp [2];
    logic [63:0] sl_rdata [2];
    logic sl_rlast [2];
    logic [3:0] sl_rid [2];
    logic if_arready, if_rvalid, if_rlast, mem_arready, mem_rvalid, mem_rlast;
    logic io_arvalid, io_rready, clint_arvalid, clint_rready;
    logic [1:0] if_rresp, mem_rresp;
    logic [63:0] if_rdata, mem_rdata;
    logic [3:0] if_rid, mem_rid, io_arid, clint_arid;
    logic [31:0] io_araddr, clint_araddr;
    logic [7:0] io_arlen, clint_arlen;
    // Bookkeeping per master (0 is IF and 1 is MEM)
    logic outstanding [2];
    logic [31:0] out_addr [2];
    logic [7:0] out_len [2];
    logic out_tgt [2];
    logic [7:0] beat_idx [2];
    int cycles = 0;

    axi_read_arbiter i_dut (
        .clk(clk), .rst(rst),
        .if_arvalid(ar_valid[0]), .if_araddr(ar_addr[0]), .if_arid(`ARB_ID_IF),
        .if_arlen(ar_len[0]), .if_arready(if_arready), .if_rready(mst_rready[0]),
        .if_rvalid(if_rvalid), .if_rresp(if_rresp), .if_rdata(if_rdata),
        .if_rlast(if_rlast), .if_rid(if_rid),
        .mem_arvalid(ar_valid[1]), .mem_araddr(ar_addr[1]), .mem_arid(`ARB_ID_MEM),
        .mem_arlen(ar_len[1]), .mem_arready(mem_arready), .mem_rready(mst_rready[1]),
        .mem_rvalid(mem_rvalid), .mem_rresp(mem_rresp), .mem_rdata(mem_rdata),
        .mem_rlast(mem_rlast), .mem_rid(mem_rid),
        .io_arvalid(io_arvalid), .io_araddr(io_araddr), .io_arid(io_arid),
        .io_arlen(io_arlen), .io_arready(sl_arready[0]), .io_rready(io_rready),
        .io_rvalid(sl_rvalid[0]), .io_rresp(sl_rresp[0]), .io_rdata(sl_rdata[0]),
        .io_rlast(sl_rlast[0]), .io_rid(sl_rid[0]),
        .clint_arvalid(clint_arvalid), .clint_araddr(clint_araddr), .clint_arid(clint_arid),
        .clint_arlen(clint_arlen), .clint_arready(sl_arready[1]), .clint_rready(clint_rready),
        .clint_rvalid(sl_rvalid[1]), .clint_rresp(sl_rresp[1]), .clint_rdata(sl_rdata[1]),
        .clint_rlast(sl_rlast[1]), .clint_rid(sl_rid[1])
    );

    always #5 clk = ~clk;

    function automatic logic expected_target(input int m, input logic [31:0] addr);
        if (m == 0) return 1'b0; // Fetch always goes to io
        return (addr >= `ARB_CLINT_TIME_LO && addr <= `ARB_CLINT_TIME_HI) ||
               (addr >= `ARB_CLINT_CMP_LO && addr <= `ARB_CLINT_CMP_HI);
    endfunction

    function automatic logic [63:0] expected_beat(input logic tgt, input logic [31:0] addr,
                                                  input logic [7:0] beat);
        logic [7:0] tag;
        tag = tgt ? 8'hc0 : 8'ha0;
        return {tag, 24'h0, addr + 32'(beat)};
    endfunction

    task automatic stop_run();
        $display("FAIL: see errors above");
        $fatal(1);
    endtask

    task automatic report_error(input string msg);
        $display("ERROR at %0t: %s", $time, msg);
        stop_run();
    endtask

    task automatic check_val(input string what, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            $display("FAILED at %0t: %s got %h expected %h", $time, what, got, exp);
            stop_run();
        end
    endtask

    // Slave model for io (t=0) or CLINT (t=1)
    task automatic slave_loop(input int t);
        logic [3:0] id;
        logic [31:0] addr;
        logic [7:0] len;
        forever begin
            @(posedge clk);
            while (!(t == 1 ? clint_arvalid : io_arvalid)) @(posedge clk);
            @(negedge clk);
            repeat ($urandom % 4) @(negedge clk);
            sl_arready[t] = 1'b1;
            @(posedge clk);
            id = (t == 1) ? clint_arid : io_arid;
            addr = (t == 1) ? clint_araddr : io_araddr;
            len = (t == 1) ? clint_arlen : io_arlen;
            @(negedge clk);
            sl_arready[t] = 1'b0;
            if (id > 4'd1 || !outstanding[id[0]])
                report_error($sformatf("request with id %0d reached a slave unasked", id));
            check_val("routing target", 64'(t), 64'(out_tgt[id[0]]));
            check_val("araddr", 64'(addr), 64'(out_addr[id[0]]));
            check_val("arlen", 64'(len), 64'(out_len[id[0]]));
            for (int b = 0; b <= int'(len); b++) begin
                repeat ($urandom % 3) @(negedge clk);  // Valid gaps
                sl_rvalid[t] = 1'b1;
                sl_rresp[t] = `ARB_RESP_OKAY;
                sl_rdata[t] = {(t == 1) ? 8'hc0 : 8'ha0, 24'h0, addr + 32'(b)};
                sl_rlast[t] = (b == int'(len));
                sl_rid[t] = id;
                @(posedge clk);
                while (!(t == 1 ? clint_rready : io_rready)) @(posedge clk);
                @(negedge clk);
                sl_rvalid[t] = 1'b0;
                sl_rresp[t] = 2'b11;  // Don't-care between beats
                sl_rlast[t] = 1'b0;
            end
        end
    endtask

    task automatic do_read(input int m, input logic [31:0] addr, input logic [7:0] len);
        @(negedge clk);
        out_addr[m] = addr;
        out_len[m] = len;
        out_tgt[m] = expected_target(m, addr);
        beat_idx[m] = 8'd0;
        outstanding[m] = 1'b1;
        ar_valid[m] = 1'b1;
        ar_addr[m] = addr;
        ar_len[m] = len;
        @(posedge clk);
        while (!(m == 1 ? mem_arready : if_arready)) @(posedge clk);
        @(negedge clk);
        ar_valid[m] = 1'b0;
        while (outstanding[m]) @(negedge clk);
    endtask

    always @(negedge clk) begin
        mst_rready[0] <= ($urandom % 4) != 0;  // Random back-pressure
        mst_rready[1] <= ($urandom % 4) != 0;
    end

    // Compare every R handshake and watch the AR ports
    always @(posedge clk) begin
        logic rv;
        logic [1:0] resp;
        logic [63:0] data;
        logic [3:0] rid;
        logic last;
        cycles <= cycles + 1;
        if (cycles >= 8000) report_error("timeout, the run did not finish within 8000 cycles");
        if (!rst) begin
            if (if_rvalid && mem_rvalid) report_error("both masters see rvalid at once");
            if (((io_arvalid && io_arid == `ARB_ID_MEM) ||
                 (clint_arvalid && clint_arid == `ARB_ID_MEM)) && outstanding[0])
                report_error("MEM request reached a slave while an IF burst was in flight");
            for (int m = 0; m < 2; m++) begin
                rv = (m == 1) ? mem_rvalid : if_rvalid;
                resp = (m == 1) ? mem_rresp : if_rresp;
                data = (m == 1) ? mem_rdata : if_rdata;
                rid = (m == 1) ? mem_rid : if_rid;
                last = (m == 1) ? mem_rlast : if_rlast;
                if (rv && !outstanding[m])
                    report_error($sformatf("master %0d sees rvalid without owning the path", m));
                if (rv && mst_rready[m]) begin
                    check_val("rdata", data, expected_beat(out_tgt[m], out_addr[m], beat_idx[m]));
                    check_val("rresp", 64'(resp), 64'(`ARB_RESP_OKAY));
                    check_val("rid", 64'(rid), 64'(m));
                    check_val("rlast", 64'(last), 64'(beat_idx[m] == out_len[m]));
                    if (last) outstanding[m] = 1'b0;
                    beat_idx[m] = beat_idx[m] + 8'd1;
                end
            end
        end
    end

    initial begin
        logic [31:0] a;
        void'($urandom(99656));
        for (int m = 0; m < 2; m++) begin
            ar_valid[m] = 1'b0;
            ar_addr[m] = '0;
            ar_len[m] = '0;
            mst_rready[m] = 1'b0;
            sl_arready[m] = 1'b0;
            sl_rvalid[m] = 1'b0;
            sl_rresp[m] = 2'b11;
            sl_rdata[m] = '0;
            sl_rlast[m] = 1'b0;
            sl_rid[m] = '0;
            outstanding[m] = 1'b0;
            out_addr[m] = '0;
            out_len[m] = '0;
            out_tgt[m] = 1'b0;
            beat_idx[m] = '0;
        end
        repeat (2) @(negedge clk);
        rst = 1'b0;
        @(posedge clk);
        check_val("idle io_arvalid", 64'(io_arvalid), 64'd0);
        check_val("idle clint_arvalid", 64'(clint_arvalid), 64'd0);
        check_val("idle io_rready", 64'(io_rready), 64'd0);
        check_val("idle clint_rready", 64'(clint_rready), 64'd0);
        check_val("idle if_rvalid", 64'(if_rvalid), 64'd0);
        check_val("idle mem_rvalid", 64'(mem_rvalid), 64'd0);
        fork
            slave_loop(0);
            slave_loop(1);
        join_none
        for (int i = 0; i < 40; i++) do_read(0, $urandom, 8'($urandom % 8));
        for (int i = 0; i < 40; i++) begin
            a = $urandom;
            while (expected_target(1, a)) a = $urandom;
            do_read(1, a, 8'($urandom % 8));
        end
        // Window edges first and then random offsets
        do_read(1, `ARB_CLINT_TIME_LO, 8'd0);
        do_read(1, `ARB_CLINT_TIME_HI, 8'd1);
        do_read(1, `ARB_CLINT_CMP_LO, 8'd0);
        do_read(1, `ARB_CLINT_CMP_HI, 8'd2);
        for (int i = 0; i < 26; i++) begin
            a = (($urandom % 2) != 0) ? `ARB_CLINT_TIME_LO : `ARB_CLINT_CMP_LO;
            do_read(1, a + ($urandom % 8), 8'($urandom % 8));
        end
        for (int i = 0; i < 20; i++) begin
            fork
                do_read(0, $urandom, 8'($urandom % 8));
                do_read(1, $urandom, 8'($urandom % 8));
            join
        end
        repeat (5) @(negedge clk);
        $display("PASS: all tests");
        $finish;
    end

endmodule

/* axi_read_arbiter.sv */
`timescale 1ns/1ns

module axi_read_arbiter (
    input  logic           clk,
    input  logic           rst,

    input  logic           if_arvalid,
    input  axi_pkg::addr_t if_araddr,
    input  axi_pkg::id_t   if_arid,
    input  axi_pkg::len_t  if_arlen,
    output logic           if_arready,
    input  logic           if_rready,
    output logic           if_rvalid,
    output axi_pkg::resp_t if_rresp,
    output axi_pkg::data_t if_rdata,
    output logic           if_rlast,
    output axi_pkg::id_t   if_rid,

    input  logic           mem_arvalid,
    input  axi_pkg::addr_t mem_araddr,
    input  axi_pkg::id_t   mem_arid,
    input  axi_pkg::len_t  mem_arlen,
    output logic           mem_arready,
    input  logic           mem_rready,
    output logic           mem_rvalid,
    output axi_pkg::resp_t mem_rresp,
    output axi_pkg::data_t mem_rdata,
    output logic           mem_rlast,
    output axi_pkg::id_t   mem_rid,

    output logic           io_arvalid,
    output axi_pkg::addr_t io_araddr,
    output axi_pkg::id_t   io_arid,
    output axi_pkg::len_t  io_arlen,
    input  logic           io_arready,
    output logic           io_rready,
    input  logic           io_rvalid,
    input  axi_pkg::resp_t io_rresp,
    input  axi_pkg::data_t io_rdata,
    input  logic           io_rlast,
    input  axi_pkg::id_t   io_rid,

    output logic           clint_arvalid,
    output axi_pkg::addr_t clint_araddr,
    output axi_pkg::id_t   clint_arid,
    output axi_pkg::len_t  clint_arlen,
    input  logic           clint_arready,
    output logic           clint_rready,
    input  logic           clint_rvalid,
    input  axi_pkg::resp_t clint_rresp,
    input  axi_pkg::data_t clint_rdata,
    input  logic           clint_rlast,
    input  axi_pkg::id_t   clint_rid
);

    logic               pick_if;
    logic               pick_mem;
    logic               mem_is_clint;
    arb_pkg::rd_state_e state;

    // Request priority and CLINT decode
    rd_request_select i_select (
        .*
    );

    // Read path owner
    rd_owner_fsm i_fsm (
        .*
    );

    rd_channel_steer i_steer (
        .*
    );

endmodule

/* rd_channel_steer.sv */
`timescale 1ns/1ns

module rd_channel_steer (
    input  logic               clk,
    input  logic               rst,
    input  arb_pkg::rd_state_e state,
    input  logic               mem_is_clint,
    input  logic               if_arvalid,
    input  axi_pkg::addr_t     if_araddr,
    input  axi_pkg::id_t       if_arid,
    input  axi_pkg::len_t      if_arlen,
    input  logic               if_rready,
    input  logic               mem_arvalid,
    input  axi_pkg::addr_t     mem_araddr,
    input  axi_pkg::id_t       mem_arid,
    input  axi_pkg::len_t      mem_arlen,
    input  logic               mem_rready,
    input  logic               io_arready,
    input  logic               io_rvalid,
    input  axi_pkg::resp_t     io_rresp,
    input  axi_pkg::data_t     io_rdata,
    input  logic               io_rlast,
    input  axi_pkg::id_t       io_rid,
    input  logic               clint_arready,
    input  logic               clint_rvalid,
    input  axi_pkg::resp_t     clint_rresp,
    input  axi_pkg::data_t     clint_rdata,
    input  logic               clint_rlast,
    input  axi_pkg::id_t       clint_rid,
    output logic               io_arvalid,
    output axi_pkg::addr_t     io_araddr,
    output axi_pkg::id_t       io_arid,
    output axi_pkg::len_t      io_arlen,
    output logic               io_rready,
    output logic               clint_arvalid,
    output axi_pkg::addr_t     clint_araddr,
    output axi_pkg::id_t       clint_arid,
    output axi_pkg::len_t      clint_arlen,
    output logic               clint_rready,
    output logic               if_arready,
    output logic               if_rvalid,
    output axi_pkg::resp_t     if_rresp,
    output axi_pkg::data_t     if_rdata,
    output logic               if_rlast,
    output axi_pkg::id_t       if_rid,
    output logic               mem_arready,
    output logic               mem_rvalid,
    output axi_pkg::resp_t     mem_rresp,
    output axi_pkg::data_t     mem_rdata,
    output logic               mem_rlast,
    output axi_pkg::id_t       mem_rid
);

    logic           busy;
    logic           from_mem;  // MEM is the chosen or owning master
    arb_pkg::tgt_e  tgt;
    logic           to_io;
    logic           if_owns;
    logic           mem_owns;
    logic           src_arvalid;
    axi_pkg::addr_t src_araddr;
    axi_pkg::id_t   src_arid;
    axi_pkg::len_t  src_arlen;
    logic           src_rready;
    logic           port_arready;
    logic           port_rvalid;
    axi_pkg::resp_t port_rresp;
    axi_pkg::data_t port_rdata;
    logic           port_rlast;
    axi_pkg::id_t   port_rid;

    always_comb begin
        from_mem = 1'b0;
        tgt      = arb_pkg::tgt_io;
        case (state)
            arb_pkg::st_idle: begin
                from_mem = !if_arvalid;   // IF wins when both ask
                if (!if_arvalid && mem_is_clint) begin
                    tgt = arb_pkg::tgt_clint;
                end
            end
            arb_pkg::st_mem_io: begin
                from_mem = 1'b1;
            end
            arb_pkg::st_mem_clint: begin
                from_mem = 1'b1;
                tgt      = arb_pkg::tgt_clint;
            end
            default: from_mem = 1'b0;
        endcase
    end

    assign busy     = (state != arb_pkg::st_idle);
    assign to_io    = (tgt == arb_pkg::tgt_io);
    assign if_owns  = busy && !from_mem;
    assign mem_owns = busy && from_mem;

    assign src_arvalid = from_mem ? mem_arvalid : if_arvalid;
    assign src_araddr  = from_mem ? mem_araddr : if_araddr;
    assign src_arid    = from_mem ? mem_arid : if_arid;
    assign src_arlen   = from_mem ? mem_arlen : if_arlen;
    assign src_rready  = from_mem ? mem_rready : if_rready;

    assign io_arvalid    = to_io && src_arvalid;
    assign io_araddr     = to_io ? src_araddr : '0;
    assign io_arid       = to_io ? src_arid : '0;
    assign io_arlen      = to_io ? src_arlen : '0;
    assign io_rready     = busy && to_io && src_rready;  // No beats taken in idle
    assign clint_arvalid = !to_io && src_arvalid;
    assign clint_araddr  = !to_io ? src_araddr : '0;
    assign clint_arid    = !to_io ? src_arid : '0;
    assign clint_arlen   = !to_io ? src_arlen : '0;
    assign clint_rready  = busy && !to_io && src_rready;

    // Return side of the selected port
    assign port_arready = to_io ? io_arready : clint_arready;
    assign port_rvalid  = to_io ? io_rvalid : clint_rvalid;
    assign port_rresp   = to_io ? io_rresp : clint_rresp;
    assign port_rdata   = to_io ? io_rdata : clint_rdata;
    assign port_rlast   = to_io ? io_rlast : clint_rlast;
    assign port_rid     = to_io ? io_rid : clint_rid;

    assign if_arready  = !from_mem && port_arready;
    assign mem_arready = from_mem && port_arready && (busy || mem_arvalid);

    assign if_rvalid  = if_owns && port_rvalid;
    assign if_rresp   = if_owns ? port_rresp : '0;
    assign if_rdata   = if_owns ? port_rdata : '0;
    assign if_rlast   = if_owns && port_rlast;
    assign if_rid     = if_owns ? port_rid : '0;
    assign mem_rvalid = mem_owns && port_rvalid;
    assign mem_rresp  = mem_owns ? port_rresp : '0;
    assign mem_rdata  = mem_owns ? port_rdata : '0;
    assign mem_rlast  = mem_owns && port_rlast;
    assign mem_rid    = mem_owns ? port_rid : '0;

    a_one_ar_port: assert property (@(posedge clk) disable iff (rst)
        !(io_arvalid && clint_arvalid));

    // R beats go to one master only
    a_one_r_master: assert property (@(posedge clk) disable iff (rst)
        !(if_rvalid && mem_rvalid));

endmodule

/* rd_owner_fsm.sv */
`timescale 1ns/1ns
`include "arb_defines.svh"

module rd_owner_fsm (
    input  logic               clk,
    input  logic               rst,
    input  logic               pick_if,
    input  logic               pick_mem,
    input  logic               mem_is_clint,
    input  logic               if_rready,
    input  logic               mem_rready,
    input  logic               io_rvalid,
    input  logic               io_rlast,
    input  logic               clint_rvalid,
    input  logic               clint_rlast,
    input  axi_pkg::resp_t     io_rresp,
    input  axi_pkg::resp_t     clint_rresp,
    input  axi_pkg::id_t       io_rid,
    input  axi_pkg::id_t       clint_rid,
    output arb_pkg::rd_state_e state
);

    arb_pkg::rd_state_e state_next;
    logic               io_end;
    logic               clint_end;
    logic               if_io_done;
    logic               mem_io_done;
    logic               mem_clint_done;

    // Good last beat on each port
    assign io_end = io_rvalid && io_rlast &&
                    (io_rresp == `ARB_RESP_OKAY || io_rresp == `ARB_RESP_EXOKAY);
    assign clint_end = clint_rvalid && clint_rlast &&
                       (clint_rresp == `ARB_RESP_OKAY || clint_rresp == `ARB_RESP_EXOKAY);

    assign if_io_done     = io_end && if_rready && (io_rid == `ARB_ID_IF);
    assign mem_io_done    = io_end && mem_rready && (io_rid == `ARB_ID_MEM);
    assign mem_clint_done = clint_end && mem_rready && (clint_rid == `ARB_ID_MEM);

    always_comb begin
        state_next = state;
        case (state)
            arb_pkg::st_idle: begin
                if (pick_if) begin
                    state_next = arb_pkg::st_if_io;
                end else if (pick_mem) begin
                    state_next = mem_is_clint ? arb_pkg::st_mem_clint : arb_pkg::st_mem_io;
                end
            end
            arb_pkg::st_if_io: begin
                if (if_io_done) state_next = arb_pkg::st_idle;
            end
            arb_pkg::st_mem_io: begin
                if (mem_io_done) state_next = arb_pkg::st_idle;
            end
            arb_pkg::st_mem_clint: begin
                if (mem_clint_done) state_next = arb_pkg::st_idle;
            end
            default: state_next = arb_pkg::st_idle;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= arb_pkg::st_idle;
        end else begin
            state <= state_next;
        end
    end

    a_state_legal: assert property (@(posedge clk) disable iff (rst)
        state inside {arb_pkg::st_idle, arb_pkg::st_if_io,
                      arb_pkg::st_mem_io, arb_pkg::st_mem_clint});

    // No owner is taken without a request
    a_leave_idle: assert property (@(posedge clk) disable iff (rst)
        (state == arb_pkg::st_idle && !pick_if && !pick_mem) |=> state == arb_pkg::st_idle);

endmodule

/* rd_request_select.sv */
`timescale 1ns/1ns
`include "arb_defines.svh"

module rd_request_select (
    input  logic           if_arvalid,
    input  logic           mem_arvalid,
    input  axi_pkg::addr_t mem_araddr,
    output logic           pick_if,
    output logic           pick_mem,
    output logic           mem_is_clint
);

    logic in_time;
    logic in_cmp;

    // Fetch has fixed priority
    assign pick_if  = if_arvalid;
    assign pick_mem = mem_arvalid && !if_arvalid;

    assign in_time = (mem_araddr >= `ARB_CLINT_TIME_LO) && (mem_araddr <= `ARB_CLINT_TIME_HI);
    assign in_cmp  = (mem_araddr >= `ARB_CLINT_CMP_LO) && (mem_araddr <= `ARB_CLINT_CMP_HI);

    assign mem_is_clint = in_time || in_cmp; // mtime or mtimecmp

endmodule

/* arb_pkg.sv */
package arb_pkg;

    // Owner of the read path
    typedef enum logic [1:0] {
        st_idle      = 2'd0,
        st_if_io     = 2'd1,
        st_mem_io    = 2'd2,
        st_mem_clint = 2'd3
    } rd_state_e;

    typedef enum logic {
        tgt_io    = 1'b0,
        tgt_clint = 1'b1
    } tgt_e;

endpackage

/* axi_pkg.sv */
`include "arb_defines.svh"

package axi_pkg;

    typedef logic [`ARB_ADDR_W-1:0] addr_t;
    typedef logic [`ARB_DATA_W-1:0] data_t;
    typedef logic [`ARB_ID_W-1:0]   id_t;
    typedef logic [`ARB_LEN_W-1:0]  len_t;  // Beats minus one
    typedef logic [`ARB_RESP_W-1:0] resp_t;

endpackage

/* arb_defines.svh */
`ifndef ARB_DEFINES_SVH
`define ARB_DEFINES_SVH

`define ARB_ADDR_W 32
`define ARB_DATA_W 64
`define ARB_ID_W   4
`define ARB_LEN_W  8   // Beats minus one
`define ARB_RESP_W 2

`define ARB_ID_IF  4'h0
`define ARB_ID_MEM 4'h1

`define ARB_RESP_OKAY   2'b00
`define ARB_RESP_EXOKAY 2'b01

// Inclusive CLINT windows
`define ARB_CLINT_TIME_LO 32'h0200_bff8
`define ARB_CLINT_TIME_HI 32'h0200_bfff
`define ARB_CLINT_CMP_LO  32'h0200_4000
`define ARB_CLINT_CMP_HI  32'h0200_4007

`endif
